//--- sim.f
hw/lc4_pkg.sv
hw/lc4_fetch.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_hazard.sv
hw/lc4_alu.sv
hw/lc4_core.sv
sim/lc4_checker.sv
sim/lc4_core_assert.sv
sim/tb_lc4.sv

//--- run.sh
#!/bin/sh
# build and run the lc4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_lc4 -o tb_lc4

./obj_dir/tb_lc4 > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
   exit 1
fi
exit 0

//--- sim/tb_lc4.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc4;
   import lc4_pkg::*;

   localparam word_t RESET_PC = 16'h8200;
   localparam int    ROWS = 31;
   localparam int    LIMIT = 5 + 3 * ROWS + 20;

   logic      gwe;
   logic      i_rst_n;
   word_t     i_insn;
   word_t     i_dmem_rdata;
   word_t     o_pc;
   dmem_req_t o_dmem;
   retire_t   o_retire;

   word_t imem [65536];
   word_t dmem [65536];

   // {retires, instruction word}
   logic [16:0] program_rows [ROWS] = '{
      {1'b1, 16'h9205},  // const r1, 5
      {1'b1, 16'h95fd},  // const r2, -3
      {1'b1, 16'h1642},  // add r3, r1, r2 with mx on r2 and wx on r1
      {1'b1, 16'h18d1},  // sub r4, r3, r1
      {1'b1, 16'h5b03},  // and r5, r4, r3
      {1'b1, 16'h5d52},  // or r6, r5, r2
      {1'b1, 16'h5f99},  // xor r7, r6, r1
      {1'b1, 16'h127f},  // add r1, r1, #-1
      {1'b1, 16'h54a7},  // and r2, r2, #7
      {1'b1, 16'h9040},  // const r0, 0x40 as base
      {1'b1, 16'h6602},  // ldr r3, r0, #2
      {1'b1, 16'h18c1},  // add r4, r3, r1 waits on the load
      {1'b1, 16'h6a03},  // ldr r5, r0, #3
      {1'b1, 16'h7a0a},  // str r5, r0, #10 through wm
      {1'b1, 16'h6c0a},  // ldr r6, r0, #10 reads it back
      {1'b1, 16'h0e02},  // brnzp +2 behind a load
      {1'b0, 16'h9e01},  // shadow
      {1'b0, 16'h9e02},  // shadow
      {1'b1, 16'h9200},  // const r1, 0
      {1'b1, 16'h0805},  // brn not taken
      {1'b1, 16'h0401},  // brz +1 taken
      {1'b0, 16'h9409},  // shadow
      {1'b1, 16'h7404},  // str r2, r0, #4 so the next load sees a positive value
      {1'b1, 16'h1923},  // add r4, r4, #3
      {1'b1, 16'h6204},  // ldr r1, r0, #4
      {1'b1, 16'h14b0},  // add r2, r2, #-16 ties with the load on nzp
      {1'b1, 16'h0801},  // brn +1 sees the younger writer
      {1'b0, 16'h9a01},  // shadow
      {1'b1, 16'h7205},  // str r1, r0, #5
      {1'b1, 16'h1c42},  // add r6, r1, r2
      {1'b1, 16'h0000}   // nop
   };

   int    seed;
   int    cycles;
   int    timeouts;
   int    expect_rows;
   int    chk_errors;
   int    retired;
   word_t fill;

   initial gwe = 1'b0;
   always #50 gwe = ~gwe;

   always @(posedge gwe) begin
      cycles <= cycles + 1;
   end

   lc4_core #(.P_RESET_PC(RESET_PC)) uut (
      .gwe, .i_rst_n, .i_insn, .i_dmem_rdata, .o_pc, .o_dmem, .o_retire
   );

   lc4_checker #(.P_RESET_PC(RESET_PC), .P_ROWS(ROWS)) u_checker (
      .gwe, .i_rst_n, .i_dmem(o_dmem), .i_retire(o_retire),
      .o_errors(chk_errors), .o_retired(retired)
   );

   // both memories answer in the same cycle
   assign i_insn = imem[o_pc];
   assign i_dmem_rdata = dmem[o_dmem.addr];

   always @(posedge gwe) begin
      if (o_dmem.we) begin
         dmem[o_dmem.addr] <= o_dmem.wdata;
      end
   end

   initial begin
      i_rst_n = 1'b0;
      cycles = 0;
      timeouts = 0;
      expect_rows = 0;
      seed = 32'hcd86d3cb;
      for (int i = 0; i < 65536; i++) begin
         imem[i] = 16'h0000;
         fill = word_t'($random(seed));
         dmem[i] = fill;
         u_checker.shadow_mem[i] = fill;
      end
      for (int i = 0; i < ROWS; i++) begin
         imem[RESET_PC + word_t'(i)] = program_rows[i][15:0];
         u_checker.row_ok[i] = program_rows[i][16];
         u_checker.row_insn[i] = program_rows[i][15:0];
         expect_rows += program_rows[i][16] ? 1 : 0;
      end
      repeat (5) @(posedge gwe);
      @(negedge gwe);
      i_rst_n = 1'b1;
      while (retired < expect_rows && cycles < LIMIT) begin
         @(posedge gwe);
      end
      if (retired < expect_rows) begin
         timeouts = 1;
         $display("timeout: %0d of %0d rows retired after %0d cycles",
                  retired, expect_rows, cycles);
      end
      $display("errors: checker %0d, timeout %0d", chk_errors, timeouts);
      if (chk_errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/lc4_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_core_assert (
   input wire                   gwe,
   input wire                   i_rst_n,
   input wire                   i_dmem_we,
   input wire                   i_m_live,
   input wire                   i_stall,
   input wire lc4_pkg::word_t   i_pc,
   input wire lc4_pkg::retire_t i_retire
);
   import lc4_pkg::*;

   a_store_live: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_dmem_we |-> i_m_live) else $error("store issued from a bubble");

   a_single_stall: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_stall |=> !i_stall) else $error("stall held two cycles");

   // only real instructions leave side effects
   a_retire_code: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (i_retire.regfile_we || i_retire.dmem_we) |-> i_retire.stall == STALL_NONE)
      else $error("bubble record with a write");

   a_pc_hold: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_stall |=> $stable(i_pc)) else $error("pc moved during a stall");

endmodule

bind lc4_core lc4_core_assert u_assert (
   .gwe, .i_rst_n, .i_dmem_we(o_dmem.we), .i_m_live(m_live), .i_stall(stall),
   .i_pc(o_pc), .i_retire(o_retire)
);

`default_nettype wire

//--- sim/lc4_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_checker #(
   parameter lc4_pkg::word_t P_RESET_PC = 16'h8200,
   parameter int             P_ROWS = 64
) (
   input  wire                    gwe,
   input  wire                    i_rst_n,
   input  wire lc4_pkg::dmem_req_t i_dmem,
   input  wire lc4_pkg::retire_t   i_retire,
   output int                     o_errors,
   output int                     o_retired
);
   import lc4_pkg::*;

   word_t       shadow_mem [65536];
   logic        row_ok [P_ROWS];
   word_t       row_insn [P_ROWS];
   word_t       regs [8] = '{default: 16'h0000};
   logic [2:0]  nzp = 3'b000;
   word_t       exp_pc = P_RESET_PC;
   logic [31:0] store_q [$];
   logic        first = 1'b1;
   logic        prev_load = 1'b0;
   logic        prev_taken = 1'b0;
   logic [2:0]  prev_wsel = 3'b000;
   int          n_flush = 0;
   int          n_lu = 0;

   initial o_errors = 0;
   initial o_retired = 0;

   function automatic word_t sext(input word_t v, input int bits);
      word_t mask;
      mask = 16'hffff << bits;
      return v[bits-1] ? (v | mask) : (v & ~mask);
   endfunction

   function automatic logic [2:0] flags(input word_t v);
      if (v[15]) return 3'b100;
      return (v == 16'h0000) ? 3'b010 : 3'b001;
   endfunction

   task automatic mismatch(input string msg);
      o_errors++;
      $display("FAILED at %0t: %s", $time, msg);
   endtask

   task automatic check_record(input retire_t r);
      word_t       insn;
      word_t       a;
      word_t       b;
      word_t       res;
      word_t       addr;
      word_t       data;
      logic [3:0]  op;
      logic        we;
      logic        is_ld;
      logic        is_st;
      logic        taken;
      logic        dep;
      logic [31:0] st;
      int          idx;
      insn = r.insn;
      op = insn[15:12];
      a = regs[insn[8:6]];
      b = regs[insn[2:0]];
      {we, is_ld, is_st, taken, res, addr, data} = '0;
      case (op)
         OP_ARITH: begin
            we = 1'b1;
            if (insn[5]) res = a + sext(insn, 5);
            else res = (insn[5:3] == 3'b010) ? a - b : a + b;
         end
         OP_LOGIC: begin
            we = 1'b1;
            if (insn[5]) res = a & sext(insn, 5);
            else if (insn[4:3] == 2'b10) res = a | b;
            else if (insn[4:3] == 2'b11) res = a ^ b;
            else res = a & b;
         end
         OP_LDR: begin
            addr = a + sext(insn, 6);
            res = shadow_mem[addr];
            data = res;
            {we, is_ld} = 2'b11;
         end
         OP_STR: begin
            addr = a + sext(insn, 6);
            data = regs[insn[11:9]];
            is_st = 1'b1;
         end
         OP_CONST: begin
            res = sext(insn, 9);
            we = 1'b1;
         end
         default: taken = (op == OP_BR) && |(insn[11:9] & nzp);
      endcase
      // a load delays any reader of its register and any branch
      dep = prev_load &&
            ((op inside {OP_ARITH, OP_LOGIC, OP_LDR, OP_STR} && insn[8:6] == prev_wsel) ||
             (op inside {OP_ARITH, OP_LOGIC} && !insn[5] && insn[2:0] == prev_wsel) ||
             (op == OP_BR && |insn[11:9]));
      if (!first && n_lu != (dep ? 1 : 0))
         mismatch($sformatf("pc %h saw %0d load_use bubbles", r.pc, n_lu));
      if (!first && n_flush != (prev_taken ? 2 : 0))
         mismatch($sformatf("pc %h saw %0d flush bubbles", r.pc, n_flush));
      if (r.pc !== exp_pc)
         mismatch($sformatf("pc %h retired, expected %h", r.pc, exp_pc));
      idx = int'(r.pc - P_RESET_PC);
      if (idx < 0 || idx >= P_ROWS || !row_ok[idx])
         mismatch($sformatf("pc %h should not retire", r.pc));
      else if (r.insn !== row_insn[idx])
         mismatch($sformatf("pc %h insn %h, expected %h", r.pc, r.insn, row_insn[idx]));
      if (r.regfile_we !== we || (we && (r.wsel !== insn[11:9] || r.wdata !== res)))
         mismatch($sformatf("pc %h write r%0d=%h, expected %h", r.pc, r.wsel, r.wdata, res));
      if (r.nzp_we !== we || r.nzp_bits !== (we ? flags(res) : 3'b000))
         mismatch($sformatf("pc %h nzp_we %b nzp %b", r.pc, r.nzp_we, r.nzp_bits));
      if (r.dmem_we !== is_st ||
          ((is_ld || is_st) && (r.dmem_addr !== addr || r.dmem_data !== data)))
         mismatch($sformatf("pc %h memory %h/%h, expected %h/%h", r.pc, r.dmem_addr,
                            r.dmem_data, addr, data));
      if (is_st) begin
         if (store_q.size() == 0) begin
            mismatch($sformatf("pc %h store never reached data memory", r.pc));
         end else begin
            st = store_q.pop_front();
            if (st !== {addr, data})
               mismatch($sformatf("pc %h memory write %h, expected %h", r.pc, st, {addr, data}));
         end
         shadow_mem[addr] = data;
      end
      if (we) begin
         regs[insn[11:9]] = res;
         nzp = flags(res);
      end
      exp_pc = taken ? r.pc + 16'd1 + sext(insn, 9) : r.pc + 16'd1;
      prev_load = is_ld;
      prev_wsel = insn[11:9];
      prev_taken = taken;
      first = 1'b0;
      o_retired++;
   endtask

   // records are stable between rising edges
   always @(negedge gwe) begin
      if (i_rst_n) begin
         if (i_dmem.we) store_q.push_back({i_dmem.addr, i_dmem.wdata});
         if (i_retire.stall == STALL_FLUSH) begin
            n_flush++;
         end else if (i_retire.stall == STALL_LOAD_USE) begin
            n_lu++;
         end else begin
            check_record(i_retire);
            n_flush = 0;
            n_lu = 0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/lc4_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_core #(
   parameter lc4_pkg::word_t P_RESET_PC = 16'h8200
) (
   input  wire                 gwe,
   input  wire                 i_rst_n,
   input  wire lc4_pkg::word_t i_insn,
   input  wire lc4_pkg::word_t i_dmem_rdata,
   output lc4_pkg::word_t      o_pc,
   output lc4_pkg::dmem_req_t  o_dmem,
   output lc4_pkg::retire_t    o_retire
);
   import lc4_pkg::*;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  rs_data;
      word_t  rt_data;
      stall_e stall;
   } dx_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  result;
      word_t  store_data;
      stall_e stall;
   } xm_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  wdata;
      word_t  dmem_addr;
      word_t  dmem_data;
      stall_e stall;
   } mw_t;

   fd_t   fd;
   ctrl_t dec_ctrl;
   ctrl_t d_ctrl;
   word_t rs_data;
   word_t rt_data;
   dx_t   dx_q;
   xm_t   xm_q;
   mw_t   mw_q;
   logic  stall;
   logic  redirect;
   logic  x_live;
   logic  m_live;
   logic  w_live;
   word_t x_a;
   word_t x_b;
   word_t x_result;
   word_t m_store_data;
   word_t m_wdata;
   nzp_t  nzp_q;

   lc4_fetch #(.P_RESET_PC(P_RESET_PC)) u_fetch (
      .gwe, .i_rst_n, .i_stall(stall), .i_redirect(redirect), .i_target(x_result),
      .i_insn, .o_pc, .o_fd(fd)
   );

   lc4_decoder u_decoder (.i_insn(fd.insn), .o_ctrl(dec_ctrl));

   // a bubble in decode carries no control
   assign d_ctrl = (fd.stall == STALL_NONE) ? dec_ctrl : '0;

   lc4_regfile u_regfile (
      .gwe, .i_rst_n, .i_rs(dec_ctrl.r1sel), .i_rt(dec_ctrl.r2sel),
      .i_we(mw_q.ctrl.regfile_we), .i_rd(mw_q.ctrl.wsel), .i_wdata(mw_q.wdata),
      .o_rs_data(rs_data), .o_rt_data(rt_data)
   );

   assign x_live = dx_q.stall == STALL_NONE;
   assign m_live = xm_q.stall == STALL_NONE;
   assign w_live = mw_q.stall == STALL_NONE;

   lc4_hazard u_hazard (
      .i_d_ctrl(d_ctrl), .i_x_ctrl(dx_q.ctrl), .i_m_ctrl(xm_q.ctrl), .i_w_ctrl(mw_q.ctrl),
      .i_x_rs_data(dx_q.rs_data), .i_x_rt_data(dx_q.rt_data), .i_m_result(xm_q.result),
      .i_w_data(mw_q.wdata), .i_m_store_data(xm_q.store_data),
      .i_x_live(x_live), .i_m_live(m_live), .i_w_live(w_live),
      .o_stall(stall), .o_x_a(x_a), .o_x_b(x_b), .o_m_store_data(m_store_data)
   );

   lc4_alu u_alu (
      .i_op(dx_q.ctrl.alu_op), .i_pc(dx_q.pc), .i_insn(dx_q.insn),
      .i_a(x_a), .i_b(x_b), .o_result(x_result)
   );

   // predicted not taken, resolved here
   assign redirect = dx_q.ctrl.is_branch && |(dx_q.insn[11:9] & nzp_q);

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         dx_q <= '0;
         dx_q.stall <= STALL_FLUSH;
      end else begin
         dx_q.pc <= fd.pc;
         dx_q.insn <= fd.insn;
         dx_q.rs_data <= rs_data;
         dx_q.rt_data <= rt_data;
         if (redirect) begin
            dx_q.ctrl <= '0;
            dx_q.stall <= STALL_FLUSH;
         end else if (stall) begin
            dx_q.ctrl <= '0;
            dx_q.stall <= STALL_LOAD_USE;
         end else begin
            dx_q.ctrl <= d_ctrl;
            dx_q.stall <= fd.stall;
         end
      end
   end

   // the younger execute writer beats a load finishing in memory
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         nzp_q <= '0;
      end else if (dx_q.ctrl.nzp_we && !dx_q.ctrl.is_load) begin
         nzp_q <= nzp_of(x_result);
      end else if (xm_q.ctrl.is_load) begin
         nzp_q <= nzp_of(i_dmem_rdata);
      end
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         xm_q <= '0;
         xm_q.stall <= STALL_FLUSH;
      end else begin
         xm_q <= '{pc: dx_q.pc, insn: dx_q.insn, ctrl: dx_q.ctrl, result: x_result,
                   store_data: x_b, stall: dx_q.stall};
      end
   end

   // memory request, address only for loads and stores
   always_comb begin
      o_dmem.we = xm_q.ctrl.is_store;
      o_dmem.addr = (xm_q.ctrl.is_load || xm_q.ctrl.is_store) ? xm_q.result : '0;
      o_dmem.wdata = xm_q.ctrl.is_store ? m_store_data : '0;
   end

   assign m_wdata = xm_q.ctrl.is_load    ? i_dmem_rdata :
                    xm_q.ctrl.regfile_we ? xm_q.result  : '0;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mw_q <= '0;
         mw_q.stall <= STALL_FLUSH;
      end else begin
         mw_q <= '{pc: xm_q.pc, insn: xm_q.insn, ctrl: xm_q.ctrl, wdata: m_wdata,
                   dmem_addr: o_dmem.addr,
                   dmem_data: xm_q.ctrl.is_store ? m_store_data :
                              xm_q.ctrl.is_load  ? i_dmem_rdata : '0,
                   stall: xm_q.stall};
      end
   end

   // retire record straight from writeback
   always_comb begin
      o_retire.stall = mw_q.stall;
      o_retire.pc = mw_q.pc;
      o_retire.insn = mw_q.insn;
      o_retire.regfile_we = mw_q.ctrl.regfile_we;
      o_retire.wsel = mw_q.ctrl.wsel;
      o_retire.wdata = mw_q.wdata;
      o_retire.nzp_we = mw_q.ctrl.nzp_we;
      o_retire.nzp_bits = mw_q.ctrl.nzp_we ? nzp_of(mw_q.wdata) : 3'b000;
      o_retire.dmem_we = mw_q.ctrl.is_store;
      o_retire.dmem_addr = mw_q.dmem_addr;
      o_retire.dmem_data = mw_q.dmem_data;
   end

endmodule

`default_nettype wire

//--- hw/lc4_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
   input  wire lc4_pkg::alu_op_e i_op,
   input  wire lc4_pkg::word_t   i_pc,
   input  wire lc4_pkg::word_t   i_insn,
   input  wire lc4_pkg::word_t   i_a,
   input  wire lc4_pkg::word_t   i_b,
   output lc4_pkg::word_t        o_result
);
   import lc4_pkg::*;

   word_t imm5;
   word_t imm6;
   word_t imm9;
   word_t b_sel;

   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   // bit 5 marks the immediate add and and
   assign b_sel = i_insn[5] ? imm5 : i_b;

   always_comb begin
      case (i_op)
         ALU_ADD:   o_result = i_a + b_sel;
         ALU_SUB:   o_result = i_a - i_b;
         ALU_AND:   o_result = i_a & b_sel;
         ALU_OR:    o_result = i_a | i_b;
         ALU_XOR:   o_result = i_a ^ i_b;
         ALU_CONST: o_result = imm9;
         ALU_ADDR:  o_result = i_a + imm6;
         ALU_BRT:   o_result = i_pc + 16'd1 + imm9;
         default:   o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/lc4_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard (
   input  wire lc4_pkg::ctrl_t i_d_ctrl,
   input  wire lc4_pkg::ctrl_t i_x_ctrl,
   input  wire lc4_pkg::ctrl_t i_m_ctrl,
   input  wire lc4_pkg::ctrl_t i_w_ctrl,
   input  wire lc4_pkg::word_t i_x_rs_data,
   input  wire lc4_pkg::word_t i_x_rt_data,
   input  wire lc4_pkg::word_t i_m_result,
   input  wire lc4_pkg::word_t i_w_data,
   input  wire lc4_pkg::word_t i_m_store_data,
   input  wire                 i_x_live,
   input  wire                 i_m_live,
   input  wire                 i_w_live,
   output logic                o_stall,
   output lc4_pkg::word_t      o_x_a,
   output lc4_pkg::word_t      o_x_b,
   output lc4_pkg::word_t      o_m_store_data
);
   import lc4_pkg::*;

   logic x_load;
   logic m_fwd_ok;
   logic w_fwd_ok;

   // load data shows up one stage too late for the next instruction
   assign x_load = i_x_live && i_x_ctrl.is_load && i_x_ctrl.regfile_we;
   assign o_stall = x_load &&
                    ((i_d_ctrl.r1re && i_d_ctrl.r1sel == i_x_ctrl.wsel) ||
                     (i_d_ctrl.r2re && !i_d_ctrl.is_store &&
                      i_d_ctrl.r2sel == i_x_ctrl.wsel) ||
                     i_d_ctrl.is_branch);

   // a load in memory only holds its address
   assign m_fwd_ok = i_m_live && i_m_ctrl.regfile_we && !i_m_ctrl.is_load;
   assign w_fwd_ok = i_w_live && i_w_ctrl.regfile_we;

   function automatic word_t pick(input reg_sel_t sel, input logic re, input word_t rf_data);
      if (re && m_fwd_ok && i_m_ctrl.wsel == sel) begin
         return i_m_result;
      end
      if (re && w_fwd_ok && i_w_ctrl.wsel == sel) begin
         return i_w_data;
      end
      return rf_data;
   endfunction

   // mx before wx, newest value wins
   always_comb begin
      o_x_a = pick(i_x_ctrl.r1sel, i_x_ctrl.r1re, i_x_rs_data);
      o_x_b = pick(i_x_ctrl.r2sel, i_x_ctrl.r2re, i_x_rt_data);
   end

   // wm path for a store right behind its data producer
   assign o_m_store_data = (i_m_ctrl.is_store && w_fwd_ok &&
                            i_w_ctrl.wsel == i_m_ctrl.r2sel) ? i_w_data : i_m_store_data;

endmodule

`default_nettype wire

//--- hw/lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
   input  wire                    gwe,
   input  wire                    i_rst_n,
   input  wire lc4_pkg::reg_sel_t i_rs,
   input  wire lc4_pkg::reg_sel_t i_rt,
   input  wire                    i_we,
   input  wire lc4_pkg::reg_sel_t i_rd,
   input  wire lc4_pkg::word_t    i_wdata,
   output lc4_pkg::word_t         o_rs_data,
   output lc4_pkg::word_t         o_rt_data
);
   import lc4_pkg::*;

   word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // same-cycle write is visible to decode
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

//--- hw/lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t      o_ctrl
);
   import lc4_pkg::*;

   logic [3:0] opcode;
   logic       is_imm;
   logic       alu_ok;
   alu_op_e    alu_fn;

   assign opcode = i_insn[15:12];
   assign is_imm = i_insn[5];

   // register-register and immediate ALU forms
   always_comb begin
      alu_ok = 1'b1;
      alu_fn = ALU_ADD;
      if (is_imm) begin
         alu_fn = (opcode == OP_ARITH) ? ALU_ADD : ALU_AND;
      end else begin
         case ({opcode == OP_LOGIC, i_insn[4:3]})
            3'b000:  alu_fn = ALU_ADD;
            3'b010:  alu_fn = ALU_SUB;
            3'b100:  alu_fn = ALU_AND;
            3'b110:  alu_fn = ALU_OR;
            3'b111:  alu_fn = ALU_XOR;
            // mul, div and not are outside the subset
            default: alu_ok = 1'b0;
         endcase
      end
   end

   always_comb begin
      o_ctrl = '0;
      o_ctrl.alu_op = ALU_ADD;
      case (opcode)
         OP_ARITH, OP_LOGIC: begin
            if (alu_ok) begin
               o_ctrl.r1sel = i_insn[8:6];
               o_ctrl.r1re = 1'b1;
               o_ctrl.r2sel = i_insn[2:0];
               o_ctrl.r2re = !is_imm;
               o_ctrl.wsel = i_insn[11:9];
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we = 1'b1;
               o_ctrl.alu_op = alu_fn;
            end
         end
         OP_LDR: begin
            o_ctrl.r1sel = i_insn[8:6];
            o_ctrl.r1re = 1'b1;
            o_ctrl.wsel = i_insn[11:9];
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.is_load = 1'b1;
            o_ctrl.alu_op = ALU_ADDR;
         end
         OP_STR: begin
            // store data register sits in the destination field
            o_ctrl.r1sel = i_insn[8:6];
            o_ctrl.r1re = 1'b1;
            o_ctrl.r2sel = i_insn[11:9];
            o_ctrl.r2re = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.alu_op = ALU_ADDR;
         end
         OP_CONST: begin
            o_ctrl.wsel = i_insn[11:9];
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = ALU_CONST;
         end
         OP_BR: begin
            // no condition bits means nop
            o_ctrl.is_branch = |i_insn[11:9];
            o_ctrl.alu_op = ALU_BRT;
         end
         default: o_ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/lc4_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch #(
   parameter lc4_pkg::word_t P_RESET_PC = 16'h8200
) (
   input  wire                 gwe,
   input  wire                 i_rst_n,
   input  wire                 i_stall,
   input  wire                 i_redirect,
   input  wire lc4_pkg::word_t i_target,
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::word_t      o_pc,
   output lc4_pkg::fd_t        o_fd
);
   import lc4_pkg::*;

   word_t pc_q;

   assign o_pc = pc_q;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q <= P_RESET_PC;
         o_fd <= '0;
         o_fd.stall <= STALL_FLUSH;
      end else if (i_redirect) begin
         // wrong-path fetch turns into a bubble
         pc_q <= i_target;
         o_fd.stall <= STALL_FLUSH;
      end else if (!i_stall) begin
         pc_q <= pc_q + 16'd1;
         o_fd <= '{pc: pc_q, insn: i_insn, stall: STALL_NONE};
      end
      // on a stall both the pc and the decode latch hold
   end

endmodule

`default_nettype wire

//--- hw/lc4_pkg.sv
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;
   // bit 2 negative, bit 1 zero, bit 0 positive
   typedef logic [2:0]  nzp_t;

   // top four bits of the instruction word
   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_CONST,
      ALU_ADDR,
      ALU_BRT
   } alu_op_e;

   typedef struct packed {
      reg_sel_t r1sel;
      logic     r1re;
      reg_sel_t r2sel;
      logic     r2re;
      reg_sel_t wsel;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      alu_op_e  alu_op;
   } ctrl_t;

   typedef enum logic [1:0] {
      STALL_NONE     = 2'd0,
      STALL_FLUSH    = 2'd2,
      STALL_LOAD_USE = 2'd3
   } stall_e;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      stall_e stall;
   } fd_t;

   typedef struct packed {
      logic  we;
      word_t addr;
      word_t wdata;
   } dmem_req_t;

   typedef struct packed {
      stall_e   stall;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp_bits;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
   } retire_t;

   // flags for a value written to a register
   function automatic nzp_t nzp_of(input word_t value);
      if (value[15]) begin
         return 3'b100;
      end
      return (value == 16'd0) ? 3'b010 : 3'b001;
   endfunction

endpackage

`default_nettype wire
